/* fletcherPkg.sv */
package fletcherPkg;

    // Width of the Wishbone data bus, one word.
    localparam int BusWidth = 32;

    // Request from the bus master, held stable until ack.
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [3:0]          adr; // Byte address, word index in bits 3:2.
        logic [BusWidth-1:0] dat;
    } wbReqT;

    // Response from the slave.
    typedef struct packed {
        logic                ack; // High for exactly one cycle per transfer.
        logic [BusWidth-1:0] dat;
    } wbRspT;

    // Register map, decoded from adr[3:2].
    typedef enum logic [1:0] {
        CTRL   = 2'd0, // Write bit 0 clears, read returns the halfword count.
        DATA   = 2'd1, // Write only, feeds the checksum.
        SUM    = 2'd2, // Read the checksum.
        EXPECT = 2'd3  // Write the expected checksum, read bit 0 is the match flag.
    } regAddrE;

    // One checksum word seen either as a raw bus word or as the two sums.
    typedef union packed {
        logic [BusWidth-1:0] raw;
        struct packed {
            logic [15:0] sumB; // Running sum of sum A.
            logic [15:0] sumA; // Running sum of the halfwords.
        } sums;
    } checksumU;

endpackage

/* fletcherAccumulator.sv */
`timescale 1ns/1ps

module fletcherAccumulator #(
    parameter int Width = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic                   halfValid,
    input  logic [Width/2-1:0]     halfData,
    output fletcherPkg::checksumU  checksum,
    output logic                   busy
);

    localparam int Half = Width / 2;

    // Both sums carry one extra bit so that a single add never overflows.
    logic [Half:0] sumA;
    logic [Half:0] sumB;
    logic [Half:0] aSub;
    logic [Half:0] bSub;
    logic [Half:0] aReduced;
    logic [Half:0] bReduced;
    logic          validD; // A halfword entered sum A last cycle.

    // Subtracting all-ones leaves the top bit clear only when the sum
    // reached the modulus, so one conditional subtraction keeps each
    // value in 0 .. 2**Half-2.
    assign aSub     = sumA - {1'b0, {Half{1'b1}}};
    assign bSub     = sumB - {1'b0, {Half{1'b1}}};
    assign aReduced = aSub[Half] ? sumA : aSub;
    assign bReduced = bSub[Half] ? sumB : bSub;

    always_ff @(posedge clk) begin
        if (rst) begin
            sumA   <= '0;
            sumB   <= '0;
            validD <= 1'b0;
        end else if (clear) begin
            sumA   <= '0;
            sumB   <= '0;
            validD <= 1'b0;
        end else begin
            validD <= halfValid;
            if (halfValid) begin
                sumA <= aReduced + {1'b0, halfData}; // Stage A.
            end
            if (validD) begin
                sumB <= bReduced + aReduced; // Stage B uses the freshly updated A.
            end
        end
    end

    // Sums are zero-extended into the 16-bit fields for narrow checksums.
    always_comb begin
        checksum           = '0;
        checksum.sums.sumB = 16'(bReduced[Half-1:0]);
        checksum.sums.sumA = 16'(aReduced[Half-1:0]);
    end

    // A halfword is in flight while it sits at stage A or its B update is pending.
    assign busy = halfValid | validD;

endmodule

/* fletcherWordFeeder.sv */
`timescale 1ns/1ps

module fletcherWordFeeder #(
    parameter int Width = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wordValid,
    input  logic [fletcherPkg::BusWidth-1:0] wordData,
    output logic                             halfValid,
    output logic [Width/2-1:0]               halfData,
    output logic                             busy
);

    import fletcherPkg::*;

    localparam int Half     = Width / 2;
    localparam int Pieces   = BusWidth / Half;
    localparam int CntWidth = $clog2(Pieces + 1);

    logic [BusWidth-1:0] shiftReg;  // Remaining pieces, next one in the low bits.
    logic [CntWidth-1:0] pieceCnt;  // Pieces still to be sent.

    // Counts down the pieces of the accepted word.
    always_ff @(posedge clk) begin
        if (rst) begin
            pieceCnt <= '0;
        end else if (wordValid && pieceCnt == '0) begin
            pieceCnt <= CntWidth'(Pieces); // Word accepted, the low piece leaves next cycle.
        end else if (pieceCnt != '0) begin
            pieceCnt <= pieceCnt - 1'b1;
        end
    end

    // Word storage. Shifted down by one piece each time a piece leaves.
    always_ff @(posedge clk) begin
        if (wordValid && pieceCnt == '0) begin
            shiftReg <= wordData;
        end else if (pieceCnt != '0) begin
            shiftReg <= shiftReg >> Half;
        end
    end

    assign halfValid = (pieceCnt != '0);
    assign halfData  = shiftReg[Half-1:0];

    // Busy from the first piece out until the last piece has left.
    assign busy = (pieceCnt != '0);

endmodule

/* fletcherWbRegs.sv */
`timescale 1ns/1ps

module fletcherWbRegs (
    input  logic                             clk,
    input  logic                             rst,
    input  fletcherPkg::wbReqT               wbReq,
    output fletcherPkg::wbRspT               wbRsp,
    output logic                             wordValid,
    output logic [fletcherPkg::BusWidth-1:0] wordData,
    input  logic                             feedBusy,
    input  logic                             accBusy,
    input  logic                             halfValid,
    input  fletcherPkg::checksumU            checksum,
    output logic                             clear
);

    import fletcherPkg::*;

    logic                ackQ;      // Doubles as the acked flag for the current transfer.
    logic [BusWidth-1:0] rdData;
    logic [BusWidth-1:0] readMux;
    logic [15:0]         halfCount;
    logic [BusWidth-1:0] expected;
    logic                match;
    logic                reqActive;
    logic                ready;
    logic                accept;
    regAddrE             addr;

    assign addr = regAddrE'(wbReq.adr[3:2]);

    // A transfer is pending until it has been acked once.
    assign reqActive = wbReq.cyc & wbReq.stb & ~ackQ;

    // Stall rules. DATA writes wait for an idle feeder, SUM reads wait
    // until every written halfword has passed both accumulator stages.
    always_comb begin
        ready = 1'b1;
        case (addr)
            DATA: begin
                if (wbReq.we) begin
                    ready = ~feedBusy;
                end
            end
            SUM: begin
                if (!wbReq.we) begin
                    ready = ~feedBusy & ~accBusy;
                end
            end
            default: begin
                ready = 1'b1;
            end
        endcase
    end

    assign accept = reqActive & ready;

    // The word goes to the feeder in the same cycle the write is accepted.
    assign wordValid = accept & wbReq.we & (addr == DATA);
    assign wordData  = wbReq.dat;

    assign match = (checksum.raw == expected);

    // Read data, selected by the word index.
    always_comb begin
        readMux = '0;
        case (addr)
            CTRL:    readMux[15:0] = halfCount;
            SUM:     readMux       = checksum.raw;
            EXPECT:  readMux[0]    = match;
            default: readMux       = '0; // DATA is write only.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ackQ      <= 1'b0;
            clear     <= 1'b0;
            halfCount <= '0;
            expected  <= '0;
        end else begin
            ackQ  <= accept;
            // Clear is high alongside ack and takes effect the cycle after.
            clear <= accept & wbReq.we & (addr == CTRL) & wbReq.dat[0];

            if (clear) begin
                halfCount <= '0;
            end else if (halfValid) begin
                halfCount <= halfCount + 1'b1;
            end

            if (accept && wbReq.we && addr == EXPECT) begin
                expected <= wbReq.dat;
            end
        end
    end

    // Read data is captured with the ack and only meaningful while ack is high.
    always_ff @(posedge clk) begin
        if (accept) begin
            rdData <= readMux;
        end
    end

    always_comb begin
        wbRsp     = '0;
        wbRsp.ack = ackQ;
        wbRsp.dat = rdData;
    end

endmodule

/* fletcherEngine.sv */
`timescale 1ns/1ps

module fletcherEngine #(
    parameter int Width = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  fletcherPkg::wbReqT wbReq,
    output fletcherPkg::wbRspT wbRsp
);

    import fletcherPkg::*;

    logic                wordValid;
    logic [BusWidth-1:0] wordData;
    logic                feedBusy;
    logic                accBusy;
    logic                halfValid;
    logic [Width/2-1:0]  halfData;
    logic                clear;
    checksumU            checksum;

    // Bus slave with the register file and the stall logic.
    fletcherWbRegs i_fletcherWbRegs (
        .clk       (clk),
        .rst       (rst),
        .wbReq     (wbReq),
        .wbRsp     (wbRsp),
        .wordValid (wordValid),
        .wordData  (wordData),
        .feedBusy  (feedBusy),
        .accBusy   (accBusy),
        .halfValid (halfValid),
        .checksum  (checksum),
        .clear     (clear)
    );

    // Splits each bus word into halfwords, low half first.
    fletcherWordFeeder #(
        .Width (Width)
    ) i_fletcherWordFeeder (
        .clk       (clk),
        .rst       (rst),
        .wordValid (wordValid),
        .wordData  (wordData),
        .halfValid (halfValid),
        .halfData  (halfData),
        .busy      (feedBusy)
    );

    fletcherAccumulator #(
        .Width (Width)
    ) i_fletcherAccumulator (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .halfValid (halfValid),
        .halfData  (halfData),
        .checksum  (checksum),
        .busy      (accBusy)
    );

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int HalfPeriod  = 5,
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk; // 10 ns period with the default.
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(negedge clk); // Covers the first ten rising edges.
        rst = 1'b0;
    end

endmodule

/* fletcherMonitor.sv */
`timescale 1ns/1ps

module fletcherMonitor (
    input  logic               clk,
    input  logic               rst,
    input  fletcherPkg::wbReqT wbReq,
    input  fletcherPkg::wbRspT wbRsp,
    input  logic [31:0]        fileExp,
    output int                 readCount,
    output int                 modelErrors,
    output int                 fileErrors,
    output int                 protocolErrors
);

    import fletcherPkg::*;

    logic [15:0] modelA;
    logic [15:0] modelB;
    logic [15:0] modelCount;  // Halfwords since the last clear.
    logic [31:0] modelExpect;
    logic        ackSeen;     // Ack was high in the previous cycle.

    // Addition modulo 65535 on 16-bit operands.
    function automatic logic [15:0] addMod(input logic [15:0] x, input logic [15:0] y);
        logic [16:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    function automatic string regName(input logic [1:0] idx);
        case (regAddrE'(idx))
            CTRL:    return "CTRL";
            DATA:    return "DATA";
            SUM:     return "SUM";
            default: return "EXPECT";
        endcase
    endfunction

    always @(posedge clk) begin
        logic [31:0] modelRead;
        if (rst) begin
            modelA = '0;
            modelB = '0;
            modelCount = '0;
            modelExpect = '0;
            ackSeen = 1'b0;
            readCount = 0;
            modelErrors = 0;
            fileErrors = 0;
            protocolErrors = 0;
        end else begin
            if (wbRsp.ack && ackSeen) begin
                protocolErrors++;
                $display("ack stayed high for more than one cycle at %0t", $time);
            end
            if (wbRsp.ack && wbReq.we) begin
                case (regAddrE'(wbReq.adr[3:2]))
                    CTRL: begin
                        if (wbReq.dat[0]) begin
                            modelA = '0; // Clear resets both sums and the count.
                            modelB = '0;
                            modelCount = '0;
                        end
                    end
                    DATA: begin
                        modelA = addMod(modelA, wbReq.dat[15:0]); // Low half first.
                        modelB = addMod(modelB, modelA);
                        modelA = addMod(modelA, wbReq.dat[31:16]);
                        modelB = addMod(modelB, modelA);
                        modelCount = modelCount + 16'd2;
                    end
                    SUM: begin
                    end
                    default: modelExpect = wbReq.dat;
                endcase
            end else if (wbRsp.ack) begin
                case (regAddrE'(wbReq.adr[3:2]))
                    CTRL:    modelRead = {16'h0000, modelCount};
                    DATA:    modelRead = '0;
                    SUM:     modelRead = {modelB, modelA};
                    default: modelRead = {31'd0, ({modelB, modelA} == modelExpect)};
                endcase
                readCount++;
                if (wbRsp.dat !== modelRead) begin
                    modelErrors++;
                    $display("error: wbRsp.dat on %s read, model 0x%08h, got 0x%08h",
                             regName(wbReq.adr[3:2]), modelRead, wbRsp.dat);
                end
                if (wbRsp.dat !== fileExp) begin
                    fileErrors++;
                    $display("error: wbRsp.dat on %s read, file 0x%08h, got 0x%08h",
                             regName(wbReq.adr[3:2]), fileExp, wbRsp.dat);
                end
            end
            ackSeen = wbRsp.ack;
        end
    end

endmodule

/* fletcherEngineTb.sv */
`timescale 1ns/1ps

module fletcherEngineTb;

    import fletcherPkg::*;

    logic        clk;
    logic        rst;
    wbReqT       wbReq;
    wbRspT       wbRsp;
    logic [31:0] fileExp;    // Expected read data of the current line.
    int          readCount;
    int          modelErrors;
    int          fileErrors;
    int          protocolErrors;
    int          seed = 5091;
    bit          loaded;

    bit          opQ[$];     // One entry per file line, 1 for a write.
    logic [1:0]  adrQ[$];
    logic [31:0] datQ[$];
    logic [31:0] expQ[$];

    tbClock i_tbClock (
        .clk (clk),
        .rst (rst)
    );

    fletcherEngine #(
        .Width (32)
    ) i_fletcherEngine (
        .clk   (clk),
        .rst   (rst),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    fletcherMonitor i_fletcherMonitor (
        .clk            (clk),
        .rst            (rst),
        .wbReq          (wbReq),
        .wbRsp          (wbRsp),
        .fileExp        (fileExp),
        .readCount      (readCount),
        .modelErrors    (modelErrors),
        .fileErrors     (fileErrors),
        .protocolErrors (protocolErrors)
    );

    // Lines that do not start with W or R are skipped.
    task automatic loadFile(output bit ok);
        int          fd;
        int          n;
        string       line;
        byte         opChar;
        logic [31:0] wAdr;
        logic [31:0] wDat;
        logic [31:0] wExp;
        ok = 1'b0;
        fd = $fopen("fletcherInput.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%c %h %h %h", opChar, wAdr, wDat, wExp);
                if (n == 4 && (opChar == "W" || opChar == "R")) begin
                    opQ.push_back(opChar == "W");
                    adrQ.push_back(wAdr[1:0]);
                    datQ.push_back(wDat);
                    expQ.push_back(wExp);
                end
            end
            $fclose(fd);
            ok = (opQ.size() > 0);
        end
    endtask

    // One classic cycle, entered and left on a falling edge.
    task automatic busTransfer(input bit write, input logic [1:0] wordAdr,
                               input logic [31:0] data, input logic [31:0] expData);
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = write;
        wbReq.adr = {wordAdr, 2'b00};
        wbReq.dat = write ? data : '0;
        fileExp   = expData;
        @(negedge clk);
        while (!wbRsp.ack) begin
            @(negedge clk);
        end
        @(negedge clk); // Hold the request through the ack edge.
        wbReq = '0;
    endtask

    initial begin
        bit ok;
        int reads;
        int gap;
        wbReq   = '0;
        fileExp = '0;
        loaded  = 1'b0;
        reads   = 0;
        loadFile(ok);
        if (!ok) begin
            $display("could not read any bus operation from fletcherInput.txt");
            $display("TB FAILED");
        end else begin
            loaded = 1'b1;
            wait (rst == 1'b0);
            @(negedge clk);
            foreach (opQ[i]) begin
                gap = $unsigned($random(seed)) % 4;
                if (i > 0 && opQ[i-1] && adrQ[i-1] == DATA) begin
                    gap = 0; // Straight after a DATA write, so the ack stalls are hit.
                end
                repeat (gap) @(negedge clk); // Idle gap.
                busTransfer(opQ[i], adrQ[i], datQ[i], expQ[i]);
                reads += opQ[i] ? 0 : 1;
            end
            repeat (2) @(negedge clk);
            if (readCount != reads) begin
                $display("the monitor saw %0d reads but %0d were issued", readCount, reads);
            end
            $display("Summary: %0d reads, %0d model errors, %0d file errors, %0d protocol errors",
                     readCount, modelErrors, fileErrors, protocolErrors);
            if (modelErrors == 0 && fileErrors == 0 && protocolErrors == 0
                    && readCount == reads) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
        end
        $finish;
    end

    // Watchdog sized from the number of file lines plus the reset time.
    initial begin
        int limit;
        wait (loaded);
        limit = opQ.size() * 200 + 10;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped acknowledging transfers", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* fletcherEngine.f */
fletcherPkg.sv
fletcherAccumulator.sv
fletcherWordFeeder.sv
fletcherWbRegs.sv
fletcherEngine.sv
tbClock.sv
fletcherMonitor.sv
fletcherEngineTb.sv

/* Bender.yml */
package:
  name: fletcherEngine

sources:
  - fletcherPkg.sv
  - fletcherAccumulator.sv
  - fletcherWordFeeder.sv
  - fletcherWbRegs.sv
  - fletcherEngine.sv
  - target: test
    files:
      - tbClock.sv
      - fletcherMonitor.sv
      - fletcherEngineTb.sv

/* fletcherInput.txt */
# op word_adr data expected_read (hex), op W = write, R = read
# word_adr 0 = CTRL, 1 = DATA, 2 = SUM, 3 = EXPECT, expected_read is ignored for writes
R 2 00000000 00000000
R 0 00000000 00000000
W 1 00020001 00000000
W 1 00040003 00000000
R 2 00000000 0014000A
R 0 00000000 00000004
W 3 0014000A 00000000
R 3 00000000 00000001
W 0 00000001 00000000
R 2 00000000 00000000
R 0 00000000 00000000
W 1 FFFFFFFF 00000000
R 2 00000000 00000000
R 0 00000000 00000002
W 1 FFFEFFFE 00000000
R 2 00000000 FFFCFFFD
W 1 00030002 00000000
R 2 00000000 00000003
R 0 00000000 00000006
W 3 00000003 00000000
R 3 00000000 00000001
W 1 80008000 00000000
R 2 00000000 80070004
W 1 1234ABCD 00000000
R 2 00000000 E9DEBE05
W 1 0000FFFF 00000000
R 2 00000000 65EABE05
R 0 00000000 0000000C
W 1 00010001 00000000
W 1 00010001 00000000
W 1 00000000 00000000
R 2 00000000 DA1EBE09
R 0 00000000 00000012
W 3 DA1EBE08 00000000
R 3 00000000 00000000
W 3 DA1EBE09 00000000
R 3 00000000 00000001
W 0 00000001 00000000
R 0 00000000 00000000
W 1 00050004 00000000
R 2 00000000 000D0009
R 0 00000000 00000002
